// File: cvxif_pkg.sv
// Widths and packed structs shared by the core side and the coprocessor.
// Operands travel inside the issue request. There is no register channel.
// Every accepted instruction is treated as committed.
package cvxif_pkg;

  // Operand and result width
  localparam int unsigned XLEN = 32;

  // Instruction tag width. Ids wrap every 16 instructions
  localparam int unsigned IdWidth = 4;

  // Buffering on both sides of the issue channel
  localparam int unsigned InstrFifoDepth  = 4;
  localparam int unsigned ResultFifoDepth = 4;

  typedef logic [IdWidth-1:0] id_t;

  // Instruction word with its operands, as pushed in from outside
  typedef struct packed {
    logic [31:0]     instr;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
  } core_instr_t;

  typedef struct packed {
    logic [31:0]     instr;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    id_t             id;
  } x_issue_req_t;

  // Driven combinationally from the request in the same cycle
  typedef struct packed {
    logic accept;
    logic writeback;
  } x_issue_resp_t;

  typedef struct packed {
    id_t             id;
    logic [XLEN-1:0] data;
  } x_result_t;

  // Data is zero when illegal is set
  typedef struct packed {
    id_t             id;
    logic [XLEN-1:0] data;
    logic            illegal;
  } retire_t;

endpackage

// File: copro_pkg.sv
// Encodings understood by the example coprocessor.
// Only the custom-0 major opcode with funct7 zero is decoded.
// funct3 selects the operation, values above OP_ROTL are illegal.
package copro_pkg;

  // custom-0 major opcode
  localparam logic [6:0] CustomOpcode = 7'b000_1011;

  // funct7 must be all zero for an accepted instruction
  localparam logic [6:0] Funct7Zero = 7'b000_0000;

  // Number of operations, also the first illegal funct3 value
  localparam int unsigned NumOps = 5;

  // Encoding equals the funct3 field of the instruction
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_XOR  = 3'd3,
    OP_ROTL = 3'd4
  } copro_op_e;

  // Micro-op carried through the ALU stages
  typedef struct packed {
    copro_op_e                 op;
    logic [cvxif_pkg::XLEN-1:0] rs1;
    logic [cvxif_pkg::XLEN-1:0] rs2;
    cvxif_pkg::id_t            id;
  } copro_uop_t;

endpackage

// File: sync_fifo.sv
// Single-clock FIFO, the head is shown on data_o while not empty.
// A push while full or a pop while empty is ignored, so callers check the flags.
// Push and pop in the same cycle are both taken when the flags allow them.
`timescale 1ns/1ns

module sync_fifo #(
  parameter int unsigned Depth = 4,
  parameter type payload_t = logic,
  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1,
  localparam int unsigned CntWidth = $clog2(Depth + 1)
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                push_i,
  input  payload_t            data_i,
  output logic                full_o,
  input  logic                pop_i,
  output payload_t            data_o,
  output logic                empty_o,
  output logic [CntWidth-1:0] count_o
);

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side is active
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: copro_decoder.sv
// Purely combinational decode of a 32-bit instruction word.
// op_o reads OP_ADD whenever accept_o is low.
`timescale 1ns/1ns

module copro_decoder (
  input  logic                 [31:0] instr_i,
  output logic                        accept_o,
  output copro_pkg::copro_op_e        op_o
);

  import copro_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       funct3_ok;

  // Standard R-type field positions
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign funct3_ok = (32'(funct3) < NumOps);

  assign accept_o = (opcode == CustomOpcode) && (funct7 == Funct7Zero) && funct3_ok;

  always_comb begin
    if (accept_o) begin
      // funct3 doubles as the operation encoding
      op_o = copro_op_e'(funct3);
    end else begin
      op_o = OP_ADD;
    end
  end

endmodule

// File: copro_alu.sv
// Two-stage execution pipeline, one new micro-op per cycle, no stall input.
// The consumer must always take valid_o, the issue credits guarantee room.
// Rotate amount is rs2[4:0].
`timescale 1ns/1ns

module copro_alu (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  copro_pkg::copro_uop_t uop_i,
  output logic                  valid_o,
  output cvxif_pkg::x_result_t  result_o,
  output logic            [1:0] busy_o
);

  import cvxif_pkg::*;
  import copro_pkg::*;

  logic            s1_valid_q;
  copro_uop_t      s1_uop_q;
  logic            s2_valid_q;
  x_result_t       s2_result_q;
  logic [XLEN-1:0] alu_res;
  logic [2*XLEN-1:0] rot_tmp;

  // Stage 1 captures the micro-op
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      s1_uop_q <= uop_i;
    end
  end

  // Rotate by shifting a doubled copy and keeping the upper half
  assign rot_tmp = {s1_uop_q.rs1, s1_uop_q.rs1} << s1_uop_q.rs2[4:0];

  always_comb begin
    unique case (s1_uop_q.op)
      OP_ADD:  alu_res = s1_uop_q.rs1 + s1_uop_q.rs2;
      OP_SUB:  alu_res = s1_uop_q.rs1 - s1_uop_q.rs2;
      OP_AND:  alu_res = s1_uop_q.rs1 & s1_uop_q.rs2;
      OP_XOR:  alu_res = s1_uop_q.rs1 ^ s1_uop_q.rs2;
      OP_ROTL: alu_res = rot_tmp[2*XLEN-1:XLEN];
      default: alu_res = '0;
    endcase
  end

  // Stage 2 holds the result with its id
  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      s2_result_q <= '{id: s1_uop_q.id, data: alu_res};
    end
  end

  assign valid_o  = s2_valid_q;
  assign result_o = s2_result_q;
  assign busy_o   = {s2_valid_q, s1_valid_q};

endmodule

// File: core_issue_unit.sv
// Core side of the extension interface. Instructions are issued in arrival order.
// The head id follows the arrival index, since the FIFO never reorders.
// A rejected instruction stalls issue until its illegal retire has left.
// Coprocessor results win the retire port over a pending rejection.
`timescale 1ns/1ns

module core_issue_unit (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    instr_valid_i,
  output logic                    instr_ready_o,
  input  cvxif_pkg::core_instr_t  instr_i,
  output logic                    issue_valid_o,
  input  logic                    issue_ready_i,
  output cvxif_pkg::x_issue_req_t issue_req_o,
  input  cvxif_pkg::x_issue_resp_t issue_resp_i,
  input  logic                    result_valid_i,
  output logic                    result_ready_o,
  input  cvxif_pkg::x_result_t    result_i,
  output logic                    retire_valid_o,
  input  logic                    retire_ready_i,
  output cvxif_pkg::retire_t      retire_o
);

  import cvxif_pkg::*;

  core_instr_t head;
  logic        fifo_full;
  logic        fifo_empty;
  logic        issue_hs;
  id_t         head_id_q;
  logic        rej_valid_q;
  id_t         rej_id_q;
  logic        rej_drain;

  sync_fifo #(
    .Depth     ( InstrFifoDepth ),
    .payload_t ( core_instr_t   )
  ) i_instr_fifo (
    .clk_i    ( clk_i                          ),
    .arst_n_i ( arst_n_i                       ),
    .push_i   ( instr_valid_i && instr_ready_o ),
    .data_i   ( instr_i                        ),
    .full_o   ( fifo_full                      ),
    .pop_i    ( issue_hs                       ),
    .data_o   ( head                           ),
    .empty_o  ( fifo_empty                     ),
    .count_o  (                                )
  );

  assign instr_ready_o = !fifo_full;

  // Hold issue while a rejection still waits for the retire port
  assign issue_valid_o = !fifo_empty && !rej_valid_q;
  assign issue_hs      = issue_valid_o && issue_ready_i;

  assign issue_req_o = '{
    instr: head.instr,
    rs1:   head.rs1,
    rs2:   head.rs2,
    id:    head_id_q
  };

  // Id of the FIFO head, counts every instruction that left
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_id_q <= '0;
    end else if (issue_hs) begin
      head_id_q <= head_id_q + 1'b1;
    end
  end

  // Reject register drains only on a cycle without a result
  assign rej_drain = rej_valid_q && !result_valid_i && retire_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rej_valid_q <= 1'b0;
    end else if (issue_hs && !issue_resp_i.accept) begin
      rej_valid_q <= 1'b1;
    end else if (rej_drain) begin
      rej_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_hs && !issue_resp_i.accept) begin
      rej_id_q <= head_id_q;
    end
  end

  // Retire arbitration
  assign result_ready_o = retire_ready_i;
  assign retire_valid_o = result_valid_i || rej_valid_q;

  always_comb begin
    if (result_valid_i) begin
      retire_o = '{id: result_i.id, data: result_i.data, illegal: 1'b0};
    end else begin
      retire_o = '{id: rej_id_q, data: '0, illegal: 1'b1};
    end
  end

endmodule

// File: cvxif_example_copro.sv
// Example coprocessor behind the issue and result channels.
// issue_ready counts queued results plus ALU stages against the result FIFO depth,
// so the ALU never has to stall. Rejected issues leave no state behind.
`timescale 1ns/1ns

module cvxif_example_copro (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  input  cvxif_pkg::x_issue_req_t  issue_req_i,
  output cvxif_pkg::x_issue_resp_t issue_resp_o,
  output logic                     result_valid_o,
  input  logic                     result_ready_i,
  output cvxif_pkg::x_result_t     result_o
);

  import cvxif_pkg::*;
  import copro_pkg::*;

  localparam int unsigned CntWidth = $clog2(ResultFifoDepth + 1);

  logic                dec_accept;
  copro_op_e           dec_op;
  copro_uop_t          uop;
  logic                alu_valid;
  x_result_t           alu_result;
  logic [1:0]          alu_busy;
  logic                res_empty;
  logic [CntWidth-1:0] res_count;
  logic [CntWidth:0]   credits_used;

  copro_decoder i_decoder (
    .instr_i  ( issue_req_i.instr ),
    .accept_o ( dec_accept        ),
    .op_o     ( dec_op            )
  );

  assign issue_resp_o = '{accept: dec_accept, writeback: dec_accept};

  // Entries already promised to the result FIFO
  assign credits_used  = (CntWidth + 1)'(res_count) + alu_busy[0] + alu_busy[1];
  assign issue_ready_o = (credits_used < (CntWidth + 1)'(ResultFifoDepth));

  assign uop = '{
    op:  dec_op,
    rs1: issue_req_i.rs1,
    rs2: issue_req_i.rs2,
    id:  issue_req_i.id
  };

  copro_alu i_alu (
    .clk_i    ( clk_i                                        ),
    .arst_n_i ( arst_n_i                                     ),
    .valid_i  ( issue_valid_i && issue_ready_o && dec_accept ),
    .uop_i    ( uop                                          ),
    .valid_o  ( alu_valid                                    ),
    .result_o ( alu_result                                   ),
    .busy_o   ( alu_busy                                     )
  );

  sync_fifo #(
    .Depth     ( ResultFifoDepth ),
    .payload_t ( x_result_t      )
  ) i_result_fifo (
    .clk_i    ( clk_i          ),
    .arst_n_i ( arst_n_i       ),
    .push_i   ( alu_valid      ),
    .data_i   ( alu_result     ),
    .full_o   (                ),
    .pop_i    ( result_ready_i ),
    .data_o   ( result_o       ),
    .empty_o  ( res_empty      ),
    .count_o  ( res_count      )
  );

  assign result_valid_o = !res_empty;

endmodule

// File: ariane_lite.sv
// Subsystem top, core-side issue unit paired with the example coprocessor.
// The coprocessor is always present.
`timescale 1ns/1ns

module ariane_lite (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   instr_valid_i,
  output logic                   instr_ready_o,
  input  cvxif_pkg::core_instr_t instr_i,
  output logic                   retire_valid_o,
  input  logic                   retire_ready_i,
  output cvxif_pkg::retire_t     retire_o
);

  import cvxif_pkg::*;

  logic          issue_valid;
  logic          issue_ready;
  x_issue_req_t  issue_req;
  x_issue_resp_t issue_resp;
  logic          result_valid;
  logic          result_ready;
  x_result_t     result;

  core_issue_unit i_issue_unit (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_ready_o  ( instr_ready_o  ),
    .instr_i        ( instr_i        ),
    .issue_valid_o  ( issue_valid    ),
    .issue_ready_i  ( issue_ready    ),
    .issue_req_o    ( issue_req      ),
    .issue_resp_i   ( issue_resp     ),
    .result_valid_i ( result_valid   ),
    .result_ready_o ( result_ready   ),
    .result_i       ( result         ),
    .retire_valid_o ( retire_valid_o ),
    .retire_ready_i ( retire_ready_i ),
    .retire_o       ( retire_o       )
  );

  cvxif_example_copro i_copro (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .issue_valid_i  ( issue_valid  ),
    .issue_ready_o  ( issue_ready  ),
    .issue_req_i    ( issue_req    ),
    .issue_resp_o   ( issue_resp   ),
    .result_valid_o ( result_valid ),
    .result_ready_i ( result_ready ),
    .result_o       ( result       )
  );

endmodule

// File: tb_clk_gen.sv
// Free-running testbench clock and an active-low reset.
// Reset is released a short delay after the last reset cycle's rising edge.
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

// File: tb_ariane_lite.sv
// Testbench for ariane_lite. Inputs are driven 2 ns after the rising edge.
// Retires are sampled on the falling edge and matched by id to a reference model.
// Ids wrap at 16, so fewer than 16 instructions may be outstanding at a time.
`timescale 1ns/1ns

module tb_ariane_lite;

  import cvxif_pkg::*;

  localparam int unsigned ClkPeriod      = 40;
  localparam int unsigned NumInstr       = 342;
  localparam int unsigned CyclesPerInstr = 20;
  localparam int unsigned BpWindow       = 60;
  localparam int unsigned DrainCycles    = 200;
  localparam logic [6:0]  Custom0        = 7'h0b;

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic        instr_ready;
  core_instr_t instr;
  logic        retire_valid;
  logic        retire_ready;
  retire_t     retire;

  retire_t     exp_q [16];
  string       exp_name [16];
  logic [15:0] exp_pending;
  string       test_name;
  int unsigned n_pushed;
  int unsigned n_retired;
  int unsigned ready_mode;
  logic        saw_full;
  logic [31:0] stim_rng;
  logic [31:0] ready_rng;

  tb_clk_gen #(.PeriodNs(ClkPeriod), .ResetCycles(8)) i_clk_gen (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  ariane_lite dut_i (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .instr_valid_i  ( instr_valid  ),
    .instr_ready_o  ( instr_ready  ),
    .instr_i        ( instr        ),
    .retire_valid_o ( retire_valid ),
    .retire_ready_i ( retire_ready ),
    .retire_o       ( retire       )
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rotl32(input logic [31:0] a, input logic [4:0] s);
    if (s == 5'd0) begin
      return a;
    end
    return (a << s) | (a >> (6'd32 - {1'b0, s}));
  endfunction

  // Expected retire of one instruction from the custom-0 R-type rules
  function automatic retire_t ref_retire(input logic [31:0] word, input logic [31:0] a,
                                         input logic [31:0] b, input id_t id);
    retire_t r;
    r.id      = id;
    r.data    = '0;
    r.illegal = 1'b1;
    if (word[6:0] == Custom0 && word[31:25] == 7'd0 && word[14:12] <= 3'd4) begin
      r.illegal = 1'b0;
      case (word[14:12])
        3'd0:    r.data = a + b;
        3'd1:    r.data = a - b;
        3'd2:    r.data = a & b;
        3'd3:    r.data = a ^ b;
        default: r.data = rotl32(a, b[4:0]);
      endcase
    end
    return r;
  endfunction

  // R-type word with fixed register fields since operands travel with the request
  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      abort_run("Value mismatch");
    end
  endtask

  task automatic push(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b);
    id_t  id;
    logic done;
    id = id_t'(n_pushed);
    if (exp_pending[id]) begin
      abort_run("Id reused while its earlier instruction has not retired");
    end else begin
      instr_valid = 1'b1;
      instr       = '{instr: word, rs1: a, rs2: b};
      done        = 1'b0;
      while (!done) begin
        @(negedge clk);
        done = instr_ready;
        @(posedge clk);
        #2;
      end
      exp_q[id]       = ref_retire(word, a, b, id);
      exp_name[id]    = test_name;
      exp_pending[id] = 1'b1;
      n_pushed++;
      instr_valid = 1'b0;
    end
  endtask

  // About one in four words is drawn from the wider illegal space when allowed
  task automatic push_random(input logic allow_illegal);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] word;
    stim_rng = lcg_next(stim_rng);
    a        = stim_rng;
    stim_rng = lcg_next(stim_rng);
    b        = stim_rng;
    stim_rng = lcg_next(stim_rng);
    word     = r_word(7'd0, 3'(int'(stim_rng[18:16]) % 5), Custom0);
    if (allow_illegal && stim_rng[31:30] == 2'b00) begin
      word = r_word(stim_rng[29:23], stim_rng[22:20], stim_rng[24] ? Custom0 : stim_rng[6:0]);
    end
    push(word, a, b);
  endtask

  // Every pushed instruction must retire within DrainCycles
  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (n_retired != n_pushed && waited < DrainCycles) begin
      @(posedge clk);
      waited++;
    end
    check(test_name, 64'(n_pushed), 64'(n_retired));
    @(posedge clk);
    #2;
  endtask

  // Retire port ready mode 0 is always high, 1 held low, 2 random
  always @(posedge clk) begin
    #2;
    if (ready_mode == 2) begin
      ready_rng    = lcg_next(ready_rng);
      retire_ready = (ready_rng[29:28] != 2'b00);
    end else begin
      retire_ready = (ready_mode == 0);
    end
  end

  // Scoreboard by id
  always @(negedge clk) begin
    if (arst_n) begin
      if (!instr_ready) begin
        saw_full = 1'b1;
      end
      if (retire_valid && retire_ready) begin
        if (!exp_pending[retire.id]) begin
          abort_run("Retire with an id that has no outstanding instruction");
        end else begin
          check(exp_name[retire.id], exp_q[retire.id], retire);
          exp_pending[retire.id] = 1'b0;
          n_retired++;
        end
      end
    end
  end

  initial begin
    #(ClkPeriod * (NumInstr * CyclesPerInstr + BpWindow + 100));
    abort_run("Watchdog expired before all tests finished");
  end

  initial begin
    instr_valid  = 1'b0;
    instr        = '0;
    retire_ready = 1'b1;
    ready_mode   = 0;
    exp_pending  = '0;
    n_pushed     = 0;
    n_retired    = 0;
    saw_full     = 1'b0;
    stim_rng     = 32'h8113_2537;
    ready_rng    = lcg_next(~32'h8113_2537);
    test_name    = "reset";
    @(posedge arst_n);
    @(posedge clk);
    #2;
    check("reset instr_ready", 64'd1, 64'(instr_ready));
    check("reset retire_valid", 64'd0, 64'(retire_valid));
    check("reset issue_valid", 64'd0, 64'(dut_i.issue_valid));
    check("reset result_valid", 64'd0, 64'(dut_i.result_valid));

    test_name = "directed";
    for (int f = 0; f < 5; f++) begin
      push(r_word(7'd0, 3'(f), Custom0), 32'hf000_0001, 32'h0000_0013);
    end
    wait_drain();

    test_name = "illegal";
    push(r_word(7'd0, 3'd0, 7'h33), 32'h1234_5678, 32'h0000_0001);
    push(r_word(7'd1, 3'd0, Custom0), 32'h1234_5678, 32'h0000_0001);
    for (int f = 5; f < 8; f++) begin
      push(r_word(7'd0, 3'(f), Custom0), 32'hdead_beef, 32'h0000_0004);
    end
    wait_drain();

    // Enough back-to-back pushes to wrap the id counter
    test_name = "ids";
    repeat (20) push_random(1'b0);
    wait_drain();

    test_name  = "backpressure";
    ready_mode = 1;
    saw_full   = 1'b0;
    fork
      repeat (12) push_random(1'b1);
      begin
        repeat (BpWindow) @(posedge clk);
        check("backpressure instr_ready fell", 64'd1, 64'(saw_full));
        ready_mode = 0;
      end
    join
    wait_drain();

    test_name  = "random";
    ready_mode = 2;
    repeat (300) push_random(1'b1);
    ready_mode = 0;
    wait_drain();

    // Any late extra retire is caught by the scoreboard here
    repeat (20) @(posedge clk);
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: vlog.f
cvxif_pkg.sv
copro_pkg.sv
sync_fifo.sv
copro_decoder.sv
copro_alu.sv
core_issue_unit.sv
cvxif_example_copro.sv
ariane_lite.sv
tb_clk_gen.sv
tb_ariane_lite.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_ariane_lite \
  -f vlog.f --Mdir obj_dir -o tb_ariane_lite

./obj_dir/tb_ariane_lite > sim.log 2>&1 || true
cat sim.log

if grep -q 'All tests passed!' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
